// ==== filelist.f ====
+incdir+logic
logic/memTypesPkg.sv
logic/sramBusPkg.sv
logic/memRequestDecode.sv
logic/sramSequencer.sv
logic/readAssembler.sv
logic/memSubsystem.sv
testbench/sramModel.sv
testbench/memSubsystemTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module memSubsystemTb -f filelist.f -o memSubsystemSim

./obj_dir/memSubsystemSim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log

// ==== testbench/memSubsystemTb.sv ====
`include "memMap_params.svh"
`default_nettype none

module memSubsystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ResetCycles = 4;
    localparam int Depth = 1 << `SRAM_ADDR_W;

    typedef struct packed {
        logic                 write;
        memTypesPkg::byteAddr addr;
        memTypesPkg::dataWord data;
        logic                 expErr;
    } stimEntry;

    logic                 clk = 1'b0;
    logic                 rst, reqValid, reqWrite, reqReady;
    memTypesPkg::byteAddr reqAddr;
    memTypesPkg::dataWord reqWriteData;
    logic                 rspValid, rspError, rspReady;
    memTypesPkg::dataLine rspLine;
    sramBusPkg::halfAddr  sramAddr;
    logic                 sramWeN, sramDqOutEn;
    sramBusPkg::halfWord  sramDqOut, modelData, sramBus;

    stimEntry             stim[$];
    sramBusPkg::halfWord  shadow [0:Depth-1];
    memTypesPkg::dataLine expLine[$];
    logic                 expError[$];
    memTypesPkg::byteAddr expAddr[$];
    logic [31:0]          rngState;
    int                   errorCount, checkCount;
    logic                 holding;
    memTypesPkg::dataLine heldLine;
    logic                 heldError;

    memSubsystem DUT (
        .clk, .rst, .reqValid, .reqWrite, .reqAddr, .reqWriteData, .reqReady,
        .rspValid, .rspLine, .rspError, .rspReady,
        .sramAddr, .sramWeN, .sramDqOut, .sramDqOutEn, .sramDqIn(sramBus)
    );

    sramModel uSram (.clk, .addr(sramAddr), .weN(sramWeN), .dataIn(sramBus), .dataOut(modelData));

    assign sramBus = sramDqOutEn ? sramDqOut : modelData;   // Shared DQ bus

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic sramBusPkg::halfWord fillPattern(input int unsigned a);
        return sramBusPkg::halfWord'(a * 32'h9e37) ^ sramBusPkg::halfWord'(a >> 16);
    endfunction

    task automatic addEntry(input logic write, input memTypesPkg::byteAddr addr,
                            input logic expErr);
        stimEntry e;
        e.write  = write;
        e.addr   = addr;
        e.data   = '0;
        e.expErr = expErr;
        if (write) begin
            rngState = xorshift32(rngState);
            e.data   = rngState;
        end
        stim.push_back(e);
    endtask

    task automatic buildTable();
        addEntry(1'b1, 32'd1024, 1'b0);
        addEntry(1'b1, 32'd1028, 1'b0);
        addEntry(1'b0, 32'd1024, 1'b0);
        addEntry(1'b1, 32'd1032, 1'b0);
        addEntry(1'b0, 32'd1036, 1'b0);          // High word never written
        addEntry(1'b0, 32'd1000, 1'b1);
        addEntry(1'b1, 32'd1000, 1'b1);          // Would land on 525288
        addEntry(1'b0, 32'd525312, 1'b1);
        addEntry(1'b1, 32'd525320, 1'b1);        // Would land on 1032
        addEntry(1'b0, 32'd1032, 1'b0);
        addEntry(1'b0, 32'd525288, 1'b0);
        addEntry(1'b1, 32'd525308, 1'b0);        // Last word of the SRAM
        addEntry(1'b0, 32'd525310, 1'b0);
        addEntry(1'b1, 32'd0, 1'b1);
        addEntry(1'b1, 32'd2050, 1'b0);          // Unaligned, word 2048
        addEntry(1'b0, 32'd2052, 1'b0);
        addEntry(1'b0, 32'hffff_fff8, 1'b1);
        addEntry(1'b0, 32'd1024, 1'b0);
    endtask

    // Expected line taken from the shadow at the time of the request
    task automatic predict(input stimEntry e);
        memTypesPkg::byteAddr offset;
        sramBusPkg::halfAddr  h;
        memTypesPkg::dataLine line;
        offset = e.addr - `MEM_BASE;
        line   = '0;
        if (e.write) begin
            if (!e.expErr) begin
                h = sramBusPkg::halfAddr'((offset >> 2) << 1);
                shadow[h]         = e.data[15:0];
                shadow[h + 2'd1]  = e.data[31:16];
            end
        end else begin
            if (!e.expErr) begin
                h    = sramBusPkg::halfAddr'((offset >> 3) << 2);
                line = {shadow[h + 2'd3], shadow[h + 2'd2], shadow[h + 2'd1], shadow[h]};
            end
            expLine.push_back(line);
            expError.push_back(e.expErr);
            expAddr.push_back(e.addr);
        end
    endtask

    task automatic checkIdle();
        checkCount++;
        assert (reqReady && !rspValid && !sramDqOutEn && sramWeN) else begin
            errorCount++;
            $display("** Error at %0t: not idle, reqReady %b rspValid %b dqOutEn %b weN %b",
                     $time, reqReady, rspValid, sramDqOutEn, sramWeN);
        end
    endtask

    task automatic checkResponse();
        memTypesPkg::dataLine line;
        logic                 err;
        memTypesPkg::byteAddr addr;
        if (expLine.size() == 0) begin
            errorCount++;
            $display("Response arrived at %0t with no read outstanding", $time);
        end else begin
            line = expLine.pop_front();
            err  = expError.pop_front();
            addr = expAddr.pop_front();
            checkCount++;
            assert (rspLine == line && rspError == err) else begin
                errorCount++;
                $display("** Error at %0t: read %h gave %h err %b, expected %h err %b",
                         $time, addr, rspLine, rspError, line, err);
            end
        end
    endtask

    task automatic runWatchdog();
        int unsigned limit;
        limit = stim.size() * 20 + ResetCycles;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, %0d read responses never arrived",
                 limit, expLine.size());
        $display("STATUS: FAIL");
        $finish;
    endtask

    always @(posedge clk) begin
        rngState = xorshift32(rngState);
        rspReady <= rngState[9];                 // Random back-pressure
    end

    // A stalled response must hold its fields until taken
    always @(negedge clk) begin
        if (!rst) begin
            if (holding) begin
                checkCount++;
                assert (rspValid && rspLine == heldLine && rspError == heldError) else begin
                    errorCount++;
                    $display("** Error at %0t: response changed while rspReady was low", $time);
                end
            end
            holding   = rspValid && !rspReady;
            heldLine  = rspLine;
            heldError = rspError;
            if (rspValid && rspReady) begin
                checkResponse();
            end
        end
    end

    initial begin
        rngState     = 32'ha2ba_42f3;
        errorCount   = 0;
        checkCount   = 0;
        holding      = 1'b0;
        rst          = 1'b1;
        reqValid     = 1'b0;
        reqWrite     = 1'b0;
        reqAddr      = '0;
        reqWriteData = '0;
        rspReady     = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            shadow[sramBusPkg::halfAddr'(i)] = fillPattern(i);
        end
        buildTable();
        fork
            runWatchdog();
        join_none
        repeat (ResetCycles) begin
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkIdle();
        @(posedge clk);
        for (int i = 0; i < stim.size(); i++) begin
            reqValid     <= 1'b1;
            reqWrite     <= stim[i].write;
            reqAddr      <= stim[i].addr;
            reqWriteData <= stim[i].data;
            @(negedge clk);
            while (!reqReady) begin
                @(negedge clk);
            end
            predict(stim[i]);                    // Transfer on the coming edge
            @(posedge clk);
        end
        reqValid <= 1'b0;
        while (expLine.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);               // Catch stray responses
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/sramModel.sv ====
`include "memMap_params.svh"
`default_nettype none

module sramModel (
    input  wire logic                clk,
    input  wire sramBusPkg::halfAddr addr,
    input  wire logic                weN,
    input  wire sramBusPkg::halfWord dataIn,
    output sramBusPkg::halfWord      dataOut
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Depth = 1 << `SRAM_ADDR_W;

    sramBusPkg::halfWord mem [0:Depth-1];

    // Every address bit shows up in the contents
    function automatic sramBusPkg::halfWord fillPattern(input int unsigned a);
        return sramBusPkg::halfWord'(a * 32'h9e37) ^ sramBusPkg::halfWord'(a >> 16);
    endfunction

    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[sramBusPkg::halfAddr'(i)] = fillPattern(i);
        end
    end

    assign dataOut = mem[addr];                  // Asynchronous read

    always @(posedge clk) begin
        if (!weN) begin
            mem[addr] = dataIn;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`default_nettype none

module memSubsystem (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 reqValid,
    input  wire logic                 reqWrite,
    input  wire memTypesPkg::byteAddr reqAddr,
    input  wire memTypesPkg::dataWord reqWriteData,
    output logic                      reqReady,
    output logic                      rspValid,
    output memTypesPkg::dataLine      rspLine,
    output logic                      rspError,
    input  wire logic                 rspReady,
    output sramBusPkg::halfAddr       sramAddr,
    output logic                      sramWeN,
    output sramBusPkg::halfWord       sramDqOut,
    output logic                      sramDqOutEn,
    input  wire sramBusPkg::halfWord  sramDqIn
);

    logic                 cmdValid;
    logic                 cmdReady;
    logic                 cmdWrite;
    logic                 cmdError;
    sramBusPkg::halfAddr  cmdStart;
    memTypesPkg::dataWord cmdData;
    logic                 halfValid;
    sramBusPkg::halfWord  halfData;
    logic                 halfLast;
    logic                 halfError;
    logic                 lineFree;

    memRequestDecode uDecode (
        .clk, .rst,
        .reqValid, .reqWrite, .reqAddr, .reqWriteData, .reqReady,
        .cmdValid, .cmdWrite, .cmdError, .cmdStart, .cmdData, .cmdReady
    );

    sramSequencer uSequencer (
        .clk, .rst,
        .cmdValid, .cmdWrite, .cmdError, .cmdStart, .cmdData, .cmdReady,
        .lineFree,
        .halfValid, .halfData, .halfLast, .halfError,
        .sramAddr, .sramWeN, .sramDqOut, .sramDqOutEn, .sramDqIn
    );

    readAssembler uAssembler (
        .clk, .rst,
        .halfValid, .halfData, .halfLast, .halfError,
        .lineFree,
        .rspValid, .rspLine, .rspError, .rspReady
    );

endmodule

`default_nettype wire

// ==== logic/readAssembler.sv ====
`default_nettype none

module readAssembler (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 halfValid,
    input  wire sramBusPkg::halfWord  halfData,
    input  wire logic                 halfLast,
    input  wire logic                 halfError,
    output logic                      lineFree,
    output logic                      rspValid,
    output memTypesPkg::dataLine      rspLine,
    output logic                      rspError,
    input  wire logic                 rspReady
);

    // Busy while a line is arriving or held
    assign lineFree = !rspValid && !halfValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rspValid <= 1'b0;
            rspError <= 1'b0;
        end else if (halfValid && halfLast) begin
            rspValid <= 1'b1;
            rspError <= halfError;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    // First halfword ends up in the lowest 16 bits
    always_ff @(posedge clk) begin
        if (halfValid) begin
            if (halfError) begin
                rspLine <= '0;
            end else begin
                rspLine <= {halfData, rspLine[63:16]};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rspValid && !rspReady |=> rspValid && $stable(rspLine) && $stable(rspError));

    // Sequencer must hold off while the line is owned by a response
    assert property (@(posedge clk) disable iff (rst) halfValid |-> !rspValid);

endmodule

`default_nettype wire

// ==== logic/sramSequencer.sv ====
`default_nettype none

module sramSequencer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cmdValid,
    input  wire logic                 cmdWrite,
    input  wire logic                 cmdError,
    input  wire sramBusPkg::halfAddr  cmdStart,
    input  wire memTypesPkg::dataWord cmdData,
    output logic                      cmdReady,
    input  wire logic                 lineFree,
    output logic                      halfValid,
    output sramBusPkg::halfWord       halfData,
    output logic                      halfLast,
    output logic                      halfError,
    output sramBusPkg::halfAddr       sramAddr,
    output logic                      sramWeN,
    output sramBusPkg::halfWord       sramDqOut,
    output logic                      sramDqOutEn,
    input  wire sramBusPkg::halfWord  sramDqIn
);

    sramBusPkg::seqState  state, stateNext;
    logic                 opWrite;
    logic                 opError;
    sramBusPkg::halfAddr  opStart;
    memTypesPkg::dataWord opData;
    sramBusPkg::halfAddr  phaseOffset;
    logic                 inPhase;
    logic                 accept;
    logic                 errorRead;

    // Reads and error reads need room in the assembler
    assign cmdReady  = (state == sramBusPkg::seqIdle) && (cmdWrite || lineFree);
    assign accept    = cmdValid && cmdReady;
    assign errorRead = accept && cmdError && !cmdWrite;

    always_comb begin
        stateNext   = state;
        phaseOffset = '0;
        inPhase     = 1'b1;
        case (state)
            sramBusPkg::seqIdle: begin
                inPhase = 1'b0;
                if (accept) begin
                    stateNext = cmdError ? sramBusPkg::seqRecover : sramBusPkg::seqPhase0;
                end
            end
            sramBusPkg::seqPhase0: stateNext = sramBusPkg::seqPhase1;
            sramBusPkg::seqPhase1: begin
                phaseOffset = 1;
                stateNext   = opWrite ? sramBusPkg::seqRecover : sramBusPkg::seqPhase2;
            end
            sramBusPkg::seqPhase2: begin
                phaseOffset = 2;
                stateNext   = sramBusPkg::seqPhase3;
            end
            sramBusPkg::seqPhase3: begin
                phaseOffset = 3;
                stateNext   = sramBusPkg::seqIdle;
            end
            default: begin
                inPhase   = 1'b0;
                stateNext = sramBusPkg::seqIdle;
            end
        endcase
    end

    assign sramAddr    = opStart + phaseOffset;
    assign sramWeN     = !(inPhase && opWrite);  // Write phases only
    // Data stays on the bus through recover for hold time
    assign sramDqOutEn = opWrite && (inPhase ||
                         (state == sramBusPkg::seqRecover && !opError));
    assign sramDqOut   = (state == sramBusPkg::seqPhase0) ? opData[15:0] : opData[31:16];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= sramBusPkg::seqIdle;
            opWrite   <= 1'b0;
            opError   <= 1'b0;
            halfValid <= 1'b0;
            halfLast  <= 1'b0;
            halfError <= 1'b0;
        end else begin
            state <= stateNext;
            if (accept) begin
                opWrite <= cmdWrite;
                opError <= cmdError;
            end
            halfValid <= (inPhase && !opWrite) || errorRead;
            halfLast  <= (state == sramBusPkg::seqPhase3) || errorRead;
            halfError <= errorRead;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opStart <= cmdStart;
            opData  <= cmdData;
        end
        halfData <= errorRead ? '0 : sramDqIn;   // Sample the async read
    end

    // Bus driven during a write and for one cycle after it
    assert property (@(posedge clk) disable iff (rst)
        !sramWeN || !$past(sramWeN) |-> sramDqOutEn);

    // Read stream never overlaps an SRAM write
    assert property (@(posedge clk) disable iff (rst) halfValid |-> sramWeN);

endmodule

`default_nettype wire

// ==== logic/memRequestDecode.sv ====
`include "memMap_params.svh"
`default_nettype none

module memRequestDecode (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 reqValid,
    input  wire logic                 reqWrite,
    input  wire memTypesPkg::byteAddr reqAddr,
    input  wire memTypesPkg::dataWord reqWriteData,
    output logic                      reqReady,
    output logic                      cmdValid,
    output logic                      cmdWrite,
    output logic                      cmdError,
    output sramBusPkg::halfAddr       cmdStart,
    output memTypesPkg::dataWord      cmdData,
    input  wire logic                 cmdReady
);

    memTypesPkg::byteAddr memAddr;
    logic                 outOfRange;
    sramBusPkg::halfAddr  startHalf;
    logic                 accept;

    assign memAddr    = reqAddr - `MEM_BASE;     // Wraps when below base
    assign outOfRange = (reqAddr < `MEM_BASE) || (memAddr >= `MEM_BYTES);

    // Reads start at the doubleword, writes at the word
    assign startHalf = reqWrite ? {memAddr[`SRAM_ADDR_W:2], 1'b0}
                                : {memAddr[`SRAM_ADDR_W:3], 2'b00};

    assign reqReady = !cmdValid || cmdReady;     // Empty or draining
    assign accept   = reqValid && reqReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmdValid <= 1'b0;
            cmdWrite <= 1'b0;
            cmdError <= 1'b0;
        end else if (reqReady) begin
            cmdValid <= reqValid;
            if (reqValid) begin
                cmdWrite <= reqWrite;
                cmdError <= outOfRange;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmdStart <= startHalf;
            cmdData  <= reqWriteData;
        end
    end

    // Buffered command must hold until the sequencer takes it
    assert property (@(posedge clk) disable iff (rst)
        cmdValid && !cmdReady |=> cmdValid && $stable({cmdWrite, cmdError, cmdStart, cmdData}));

endmodule

`default_nettype wire

// ==== logic/sramBusPkg.sv ====
`include "memMap_params.svh"
`default_nettype none

package sramBusPkg;

    // Halfword address on the SRAM pins
    typedef logic [`SRAM_ADDR_W-1:0] halfAddr;

    // One SRAM datum
    typedef logic [15:0] halfWord;

    typedef enum logic [2:0] {
        seqIdle,
        seqPhase0,
        seqPhase1,
        seqPhase2,
        seqPhase3,
        seqRecover
    } seqState;

endpackage

`default_nettype wire

// ==== logic/memTypesPkg.sv ====
`default_nettype none

package memTypesPkg;

    // Processor-side byte address
    typedef logic [31:0] byteAddr;

    // Write data from the processor, one word per request
    typedef logic [31:0] dataWord;

    // Refill line, one aligned doubleword
    typedef logic [63:0] dataLine;

endpackage

`default_nettype wire

// ==== logic/memMap_params.svh ====
`ifndef MEMMAP_PARAMS_SVH
`define MEMMAP_PARAMS_SVH

`default_nettype none

// Processor byte address where data memory begins
`define MEM_BASE 32'd1024

// Halfword address bits on the SRAM pins
`define SRAM_ADDR_W 18

// Bytes reachable through the SRAM, two per halfword location
`define MEM_BYTES (32'd1 << (`SRAM_ADDR_W + 1))

`default_nettype wire

`endif
